// File: rtl/controlUnit_cfg.svh
`ifndef CONTROL_UNIT_CFG_SVH
`define CONTROL_UNIT_CFG_SVH

// instruction field widths
`define OPCODE_W   6
`define FUNCT_W    6

`define ALUOP_W    3
`define SEL2_W     2
`define MEMTOREG_W 3

`define OP_RTYPE   6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDI    6'h08
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_LW      6'h23
`define OP_SW      6'h2b

`define FN_ADD     6'h20
`define FN_SUB     6'h22
`define FN_AND     6'h24
`define FN_SLT     6'h2a

`endif

// File: rtl/controlUnitPkg.sv
`include "controlUnit_cfg.svh"

package controlUnitPkg;

    typedef enum logic [3:0] {
        clsAluReg,
        clsAluImm,
        clsLoad,
        clsStore,
        clsBeq,
        clsBne,
        clsJump,
        clsJal,
        clsIllegal
    } instrClassT;

    // codes as the datapath ALU expects them
    typedef enum logic [`ALUOP_W-1:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3,
        aluCmp  = 3'd7
    } aluOpT;

    typedef enum logic [4:0] {
        stInit, stFetch1, stFetch2, stFetch3, stDecode,
        stAluExec, stAluWb, stImmWb,
        stMemAddr, stMemRead, stMemWait, stMdrLoad, stLoadWb, stStoreWrite,
        stBranch, stJalLink, stJump,
        stOvfTrap, stIllegalTrap, stExcWait, stExcLoad, stExcJump
    } ctrlStateT;

    typedef enum logic [`MEMTOREG_W-1:0] {
        wbAluOut    = 3'd0,
        wbMdr       = 3'd1,
        wbPcLink    = 3'd6,
        wbStackInit = 3'd7   // reset value for $sp
    } memToRegT;

    typedef enum logic [`SEL2_W-1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1,
        dstRa = 2'd2,
        dstSp = 2'd3
    } regDstT;

endpackage

// File: rtl/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf import controlUnitPkg::*; ();

    instrClassT instrClass;
    aluOpT      aluOp;
    logic       useImm;       // operand B from immediate
    logic       writeRd;
    logic       trapOverflow;
    logic       setLess;      // result is the compare flag

    modport src (output instrClass, aluOp, useImm, writeRd, trapOverflow, setLess);

    modport seq (input instrClass, trapOverflow);

    modport enc (input instrClass, aluOp, useImm, writeRd, setLess);

endinterface

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module instrDecoder import controlUnitPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    decodeIf.src                 dec
);

    always_comb begin
        dec.instrClass   = clsIllegal;
        dec.aluOp        = aluPass;
        dec.useImm       = 1'b0;
        dec.writeRd      = 1'b0;
        dec.trapOverflow = 1'b0;
        dec.setLess      = 1'b0;

        case (opcode)
            `OP_RTYPE: begin
                dec.instrClass = clsAluReg;
                dec.writeRd    = 1'b1;
                case (funct)
                    `FN_ADD: begin
                        dec.aluOp        = aluAdd;
                        dec.trapOverflow = 1'b1;
                    end
                    `FN_SUB: begin
                        dec.aluOp        = aluSub;
                        dec.trapOverflow = 1'b1;
                    end
                    `FN_AND: dec.aluOp = aluAnd;
                    `FN_SLT: begin
                        dec.aluOp   = aluCmp;
                        dec.setLess = 1'b1;
                    end
                    default: begin
                        dec.instrClass = clsIllegal; // unknown funct
                        dec.writeRd    = 1'b0;
                    end
                endcase
            end
            `OP_ADDI: begin
                dec.instrClass   = clsAluImm;
                dec.aluOp        = aluAdd;
                dec.useImm       = 1'b1;
                dec.trapOverflow = 1'b1;
            end
            `OP_ADDIU: begin
                dec.instrClass = clsAluImm;
                dec.aluOp      = aluAdd;
                dec.useImm     = 1'b1;     // no trap on unsigned add
            end
            `OP_SLTI: begin
                dec.instrClass = clsAluImm;
                dec.aluOp      = aluCmp;
                dec.useImm     = 1'b1;
                dec.setLess    = 1'b1;
            end
            `OP_LW:  dec.instrClass = clsLoad;
            `OP_SW:  dec.instrClass = clsStore;
            `OP_BEQ: dec.instrClass = clsBeq;
            `OP_BNE: dec.instrClass = clsBne;
            `OP_J:   dec.instrClass = clsJump;
            `OP_JAL: dec.instrClass = clsJal;
            default: dec.instrClass = clsIllegal;
        endcase
    end

endmodule

// File: rtl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import controlUnitPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      overflow,
    decodeIf.seq      dec,
    output ctrlStateT state
);

    ctrlStateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stInit;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stFetch1;

        case (state)
            stInit:   nextState = stFetch1;
            stFetch1: nextState = stFetch2;
            stFetch2: nextState = stFetch3;
            stFetch3: nextState = stDecode;

            stDecode: begin
                case (dec.instrClass)
                    clsAluReg,
                    clsAluImm: nextState = stAluExec;
                    clsLoad,
                    clsStore:  nextState = stMemAddr;
                    clsBeq,
                    clsBne:    nextState = stBranch;
                    clsJump:   nextState = stJump;
                    clsJal:    nextState = stJalLink;
                    default:   nextState = stIllegalTrap;
                endcase
            end

            // overflow only counts here
            stAluExec: begin
                if (overflow && dec.trapOverflow) begin
                    nextState = stOvfTrap;
                end else if (dec.instrClass == clsAluImm) begin
                    nextState = stImmWb;
                end else begin
                    nextState = stAluWb;
                end
            end

            stMemAddr: begin
                if (dec.instrClass == clsStore) begin
                    nextState = stStoreWrite;
                end else begin
                    nextState = stMemRead;
                end
            end
            stMemRead: nextState = stMemWait;
            stMemWait: nextState = stMdrLoad;
            stMdrLoad: nextState = stLoadWb;

            stJalLink: nextState = stJump;

            stOvfTrap,
            stIllegalTrap: nextState = stExcWait;
            stExcWait:     nextState = stExcLoad;  // vector read
            stExcLoad:     nextState = stExcJump;

            // write-back, store, branch, jump and exception end all refetch
            default: nextState = stFetch1;
        endcase
    end

endmodule

// File: rtl/controlEncoder.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlEncoder import controlUnitPkg::*; (
    input  ctrlStateT            state,
    decodeIf.enc                 dec,
    output logic                 pcWriteCond,
    output logic                 pcWrite,
    output logic                 memWrite,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic                 regALoad,
    output logic                 regBLoad,
    output logic                 aluSrcA,
    output logic                 epcWrite,
    output logic                 aluOutSrc,
    output logic                 aluOutWrite,
    output logic                 mdrLoad,
    output logic [`SEL2_W-1:0]   aluSrcB,
    output logic [`SEL2_W-1:0]   iOrD,
    output logic [`SEL2_W-1:0]   pcSrc,
    output logic [`SEL2_W-1:0]   eqOrNe,
    output regDstT               regDst,
    output aluOpT                aluOp,
    output memToRegT             memToReg
);

    logic [`SEL2_W-1:0] excAddr;    // exception vector address select

    assign excAddr = (dec.instrClass == clsIllegal) ? `SEL2_W'(2) : `SEL2_W'(3);

    always_comb begin
        pcWriteCond = 1'b0;
        pcWrite     = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        regALoad    = 1'b0;
        regBLoad    = 1'b0;
        aluSrcA     = 1'b0;
        epcWrite    = 1'b0;
        aluOutSrc   = 1'b0;
        aluOutWrite = 1'b0;
        mdrLoad     = 1'b0;
        aluSrcB     = '0;
        iOrD        = '0;
        pcSrc       = '0;
        eqOrNe      = '0;
        regDst      = dstRt;
        aluOp       = aluPass;
        memToReg    = wbAluOut;

        case (state)
            stInit: begin
                regWrite = 1'b1;
                regDst   = dstSp;
                memToReg = wbStackInit;
            end
            stFetch1: begin
                pcWrite = 1'b1;         // pc + 4
                aluSrcB = `SEL2_W'(1);
                aluOp   = aluAdd;
            end
            stFetch3: irWrite = 1'b1;
            stDecode: begin
                aluSrcB     = `SEL2_W'(3);  // branch target
                aluOp       = aluAdd;
                regALoad    = 1'b1;
                regBLoad    = 1'b1;
                aluOutWrite = 1'b1;
            end
            stAluExec: begin
                aluSrcA     = 1'b1;
                aluSrcB     = dec.useImm ? `SEL2_W'(2) : `SEL2_W'(0);
                aluOp       = dec.aluOp;
                aluOutSrc   = dec.setLess;
                aluOutWrite = 1'b1;
            end
            stAluWb, stImmWb: begin
                regWrite = 1'b1;
                regDst   = dec.writeRd ? dstRd : dstRt;
            end
            stMemAddr: begin
                aluSrcA     = 1'b1;
                aluSrcB     = `SEL2_W'(2);
                aluOp       = aluAdd;
                aluOutWrite = 1'b1;
            end
            stMemRead, stMemWait: iOrD = `SEL2_W'(1);
            stMdrLoad: begin
                iOrD    = `SEL2_W'(1);
                mdrLoad = 1'b1;
            end
            stLoadWb: begin
                regWrite = 1'b1;
                memToReg = wbMdr;
            end
            stStoreWrite: begin
                memWrite = 1'b1;
                iOrD     = `SEL2_W'(1);
            end
            stBranch: begin
                aluSrcA     = 1'b1;
                aluOp       = aluSub;
                pcSrc       = `SEL2_W'(1);
                eqOrNe      = (dec.instrClass == clsBeq) ? `SEL2_W'(2) : `SEL2_W'(1);
                pcWriteCond = 1'b1;
            end
            stJalLink: begin
                regWrite = 1'b1;
                regDst   = dstRa;
                memToReg = wbPcLink;
            end
            stJump: begin
                pcWrite = 1'b1;
                pcSrc   = `SEL2_W'(2);
            end
            stOvfTrap, stIllegalTrap: begin
                epcWrite = 1'b1;        // epc gets pc - 4
                aluSrcB  = `SEL2_W'(1);
                aluOp    = aluSub;
                iOrD     = excAddr;
            end
            stExcWait: iOrD = excAddr;
            stExcLoad: begin
                iOrD    = excAddr;
                mdrLoad = 1'b1;
            end
            stExcJump: begin
                pcWrite = 1'b1;
                pcSrc   = `SEL2_W'(3);
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlUnit import controlUnitPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`OPCODE_W-1:0]    opcode,
    input  logic [`FUNCT_W-1:0]     funct,
    input  logic                    overflow,
    output logic                    pcWriteCond,
    output logic                    pcWrite,
    output logic                    memWrite,
    output logic                    irWrite,
    output logic                    regWrite,
    output logic                    regALoad,
    output logic                    regBLoad,
    output logic                    aluSrcA,
    output logic                    epcWrite,
    output logic                    aluOutSrc,
    output logic                    aluOutWrite,
    output logic                    mdrLoad,
    output logic [`SEL2_W-1:0]      aluSrcB,
    output logic [`SEL2_W-1:0]      iOrD,
    output logic [`SEL2_W-1:0]      pcSrc,
    output logic [`SEL2_W-1:0]      eqOrNe,
    output logic [`SEL2_W-1:0]      regDst,
    output logic [`ALUOP_W-1:0]     aluOp,
    output logic [`MEMTOREG_W-1:0]  memToReg
);

    ctrlStateT state;

    decodeIf decBus ();

    instrDecoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (decBus.src)
    );

    controlSequencer u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .overflow (overflow),
        .dec      (decBus.seq),
        .state    (state)
    );

    controlEncoder u_encoder (
        .state       (state),
        .dec         (decBus.enc),
        .pcWriteCond (pcWriteCond),
        .pcWrite     (pcWrite),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .regALoad    (regALoad),
        .regBLoad    (regBLoad),
        .aluSrcA     (aluSrcA),
        .epcWrite    (epcWrite),
        .aluOutSrc   (aluOutSrc),
        .aluOutWrite (aluOutWrite),
        .mdrLoad     (mdrLoad),
        .aluSrcB     (aluSrcB),
        .iOrD        (iOrD),
        .pcSrc       (pcSrc),
        .eqOrNe      (eqOrNe),
        .regDst      (regDst),
        .aluOp       (aluOp),
        .memToReg    (memToReg)
    );

endmodule

// File: sim/controlUnit_sva.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlUnitSva (
    input logic               clk,
    input logic               reset,
    input logic               irWrite,
    input logic               pcWrite,
    input logic               pcWriteCond,
    input logic               memWrite,
    input logic               epcWrite,
    input logic [`SEL2_W-1:0] iOrD,
    input logic [`SEL2_W-1:0] pcSrc
);

    int failures = 0;   // failed assertion count

    irPulse: assert property (@(posedge clk) disable iff (reset) irWrite |=> !irWrite)
        else begin
            $error("irWrite stayed high for more than one cycle");
            failures++;
        end

    pcExclusive: assert property (@(posedge clk) disable iff (reset) !(pcWrite && pcWriteCond))
        else begin
            $error("pcWrite and pcWriteCond high together");
            failures++;
        end

    storeAddr: assert property (@(posedge clk) disable iff (reset) memWrite |-> iOrD == 1)
        else begin
            $error("memWrite without data address select");
            failures++;
        end

    // trap tail ends in the vector jump
    excJump: assert property (@(posedge clk) disable iff (reset)
        epcWrite |-> ##[1:4] (pcWrite && pcSrc == 3))
        else begin
            $error("epcWrite not followed by exception jump");
            failures++;
        end

endmodule

bind controlUnit controlUnitSva u_sva (
    .clk         (clk),
    .reset       (reset),
    .irWrite     (irWrite),
    .pcWrite     (pcWrite),
    .pcWriteCond (pcWriteCond),
    .memWrite    (memWrite),
    .epcWrite    (epcWrite),
    .iOrD        (iOrD),
    .pcSrc       (pcSrc)
);

// File: sim/controlUnitTb.sv
`timescale 1ns/1ps
`include "controlUnit_cfg.svh"

module controlUnitTb import controlUnitPkg::*; ();

    localparam int timeoutCycles = 20;

    typedef struct {
        string      name;
        logic [5:0] op;
        logic [5:0] fn;
        logic       ovf;
        int         cycles;     // irWrite to irWrite
        int         writes;     // regWrite pulses
        int         dst;
        int         wbSrc;
        int         epcPulses;
        int         memWrites;
        int         branches;   // pcWriteCond pulses
        int         eqSel;
        int         jumps;      // pcWrite to a jump or vector target
        int         mdrLoads;
        int         execOp;     // aluOp after decode, -1 if no ALU op
    } testEntry;

    logic                   clk;
    logic                   reset;
    logic [`OPCODE_W-1:0]   opcode;
    logic [`FUNCT_W-1:0]    funct;
    logic                   overflow;
    logic                   pcWriteCond, pcWrite, memWrite, irWrite, regWrite, regALoad;
    logic                   regBLoad, aluSrcA, epcWrite, aluOutSrc, aluOutWrite, mdrLoad;
    logic [`SEL2_W-1:0]     aluSrcB, iOrD, pcSrc, eqOrNe, regDst;
    logic [`ALUOP_W-1:0]    aluOp;
    logic [`MEMTOREG_W-1:0] memToReg;

    testEntry tbl[$];
    int       errors = 0;
    int       checks = 0;
    bit       stalled = 1'b0;

    controlUnit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void addCase(string name, logic [5:0] op, logic [5:0] fn, logic ovf,
                                    int cycles, int writes, int dst, int wbSrc,
                                    int epc, int mem, int br, int eq,
                                    int jumps, int mdr, int execOp);
        tbl.push_back(testEntry'{name, op, fn, ovf, cycles, writes, dst, wbSrc,
                                 epc, mem, br, eq, jumps, mdr, execOp});
    endfunction

    task automatic checkValue(string testName, string what, logic [31:0] expected,
                              logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic reportError(string text);
        $display("ERROR %s", text);
        errors++;
    endtask

    task automatic checkReset();
        int n = 0;
        @(negedge clk);   // one more stInit cycle after release
        checkValue("reset", "regWrite", 1, regWrite);
        checkValue("reset", "regDst", dstSp, regDst);
        checkValue("reset", "memToReg", wbStackInit, memToReg);
        while (!irWrite && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (!irWrite) begin
            reportError("no irWrite after reset was released");
            stalled = 1'b1;
        end else begin
            checkValue("reset", "fetch cycles", 3, n);
        end
    endtask

    task automatic runEntry(testEntry t);
        int          cycles = 0;
        int          writes = 0;
        int          epcs = 0;
        int          mems = 0;
        int          branches = 0;
        int          jumps = 0;
        int          mdrs = 0;
        logic [31:0] dstSeen = 'x;
        logic [31:0] wbSeen = 'x;
        logic [31:0] eqSeen = 'x;
        logic [31:0] brOpSeen = 'x;
        logic [31:0] brSrcSeen = 'x;
        logic [31:0] trapSel = 'x;
        logic [31:0] jumpSel = 'x;
        logic [31:0] loadSeen = 'x;     // {regALoad, regBLoad} in decode
        logic [31:0] strobeSeen = 'x;   // {aluSrcA, aluOutWrite} after decode
        logic [31:0] opSeen = 'x;
        logic [31:0] srcBSeen = 'x;
        logic [31:0] setSeen = 'x;
        @(posedge clk);   // irWrite edge, fields held from here on
        opcode   <= t.op;
        funct    <= t.fn;
        overflow <= t.ovf;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) loadSeen = {regALoad, regBLoad};
            if (cycles == 2) begin
                strobeSeen = {aluSrcA, aluOutWrite};
                opSeen     = aluOp;
                srcBSeen   = aluSrcB;
                setSeen    = aluOutSrc;
            end
            if (regWrite) begin
                writes++;
                dstSeen = regDst;
                wbSeen  = memToReg;
            end
            if (epcWrite) begin
                epcs++;
                trapSel = iOrD;
            end
            if (memWrite) mems++;
            if (mdrLoad) mdrs++;
            if (pcWrite && pcSrc != 0) begin
                jumps++;
                jumpSel = pcSrc;
            end
            if (pcWriteCond) begin
                branches++;
                eqSeen    = eqOrNe;
                brOpSeen  = aluOp;
                brSrcSeen = pcSrc;
            end
        end while (!irWrite && cycles < timeoutCycles);
        if (!irWrite) begin
            reportError($sformatf("%s: no irWrite within %0d cycles", t.name, timeoutCycles));
            stalled = 1'b1;
        end else begin
            checkValue(t.name, "cycles", t.cycles, cycles);
            checkValue(t.name, "regWrite pulses", t.writes, writes);
            checkValue(t.name, "epcWrite pulses", t.epcPulses, epcs);
            checkValue(t.name, "memWrite pulses", t.memWrites, mems);
            checkValue(t.name, "pcWriteCond pulses", t.branches, branches);
            checkValue(t.name, "redirect pulses", t.jumps, jumps);
            checkValue(t.name, "mdrLoad pulses", t.mdrLoads, mdrs);
            checkValue(t.name, "regALoad/regBLoad", 3, loadSeen);
            if (t.writes > 0) begin
                checkValue(t.name, "regDst", t.dst, dstSeen);
                checkValue(t.name, "memToReg", t.wbSrc, wbSeen);
            end
            if (t.epcPulses > 0) checkValue(t.name, "trap iOrD", t.ovf ? 3 : 2, trapSel);
            if (t.jumps > 0) begin
                checkValue(t.name, "jump pcSrc", (t.epcPulses > 0) ? 3 : 2, jumpSel);
            end
            if (t.branches > 0) begin
                checkValue(t.name, "eqOrNe", t.eqSel, eqSeen);
                checkValue(t.name, "branch aluOp", aluSub, brOpSeen);
                checkValue(t.name, "branch pcSrc", 1, brSrcSeen);
            end
            if (t.execOp >= 0) begin
                checkValue(t.name, "aluOp", t.execOp, opSeen);
                checkValue(t.name, "aluSrcB", (t.op == `OP_RTYPE) ? 0 : 2, srcBSeen);
                checkValue(t.name, "aluOutSrc", t.execOp == aluCmp, setSeen);
                checkValue(t.name, "aluSrcA/aluOutWrite", 3, strobeSeen);
            end
        end
    endtask

    task automatic buildTable();
        // name, opcode, funct, overflow, cycles, writes, regDst, memToReg,
        // epc, mem, br, eqOrNe, jumps, mdrLoad, aluOp
        addCase("add", `OP_RTYPE, `FN_ADD, 0, 6, 1, dstRd, wbAluOut, 0, 0, 0, 0, 0, 0, aluAdd);
        addCase("sub", `OP_RTYPE, `FN_SUB, 0, 6, 1, dstRd, wbAluOut, 0, 0, 0, 0, 0, 0, aluSub);
        addCase("and", `OP_RTYPE, `FN_AND, 0, 6, 1, dstRd, wbAluOut, 0, 0, 0, 0, 0, 0, aluAnd);
        addCase("slt", `OP_RTYPE, `FN_SLT, 0, 6, 1, dstRd, wbAluOut, 0, 0, 0, 0, 0, 0, aluCmp);
        addCase("addi", `OP_ADDI, 6'h00, 0, 6, 1, dstRt, wbAluOut, 0, 0, 0, 0, 0, 0, aluAdd);
        addCase("addiu", `OP_ADDIU, 6'h00, 0, 6, 1, dstRt, wbAluOut, 0, 0, 0, 0, 0, 0, aluAdd);
        addCase("slti", `OP_SLTI, 6'h00, 0, 6, 1, dstRt, wbAluOut, 0, 0, 0, 0, 0, 0, aluCmp);
        addCase("addiu ovf", `OP_ADDIU, 6'h00, 1, 6, 1, dstRt, wbAluOut, 0, 0, 0, 0, 0, 0, aluAdd);
        addCase("and ovf", `OP_RTYPE, `FN_AND, 1, 6, 1, dstRd, wbAluOut, 0, 0, 0, 0, 0, 0, aluAnd);
        addCase("add ovf", `OP_RTYPE, `FN_ADD, 1, 9, 0, 0, 0, 1, 0, 0, 0, 1, 1, aluAdd);
        addCase("sub ovf", `OP_RTYPE, `FN_SUB, 1, 9, 0, 0, 0, 1, 0, 0, 0, 1, 1, aluSub);
        addCase("addi ovf", `OP_ADDI, 6'h00, 1, 9, 0, 0, 0, 1, 0, 0, 0, 1, 1, aluAdd);
        addCase("lw", `OP_LW, 6'h00, 0, 9, 1, dstRt, wbMdr, 0, 0, 0, 0, 0, 1, -1);
        addCase("sw", `OP_SW, 6'h00, 0, 6, 0, 0, 0, 0, 1, 0, 0, 0, 0, -1);
        addCase("beq", `OP_BEQ, 6'h00, 0, 5, 0, 0, 0, 0, 0, 1, 2, 0, 0, -1);
        addCase("bne", `OP_BNE, 6'h00, 0, 5, 0, 0, 0, 0, 0, 1, 1, 0, 0, -1);
        addCase("j", `OP_J, 6'h00, 0, 5, 0, 0, 0, 0, 0, 0, 0, 1, 0, -1);
        addCase("jal", `OP_JAL, 6'h00, 0, 6, 1, dstRa, wbPcLink, 0, 0, 0, 0, 1, 0, -1);
        addCase("bad opcode", 6'h3f, 6'h00, 0, 8, 0, 0, 0, 1, 0, 0, 0, 1, 1, -1);
        addCase("bad funct", `OP_RTYPE, 6'h3f, 0, 8, 0, 0, 0, 1, 0, 0, 0, 1, 1, -1);
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        buildTable();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        checkReset();
        foreach (tbl[i]) begin
            if (!stalled) runEntry(tbl[i]);
        end
        checkValue("assertions", "concurrent assertion failures", 0, u_dut.u_sva.failures);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/controlUnitPkg.sv
rtl/decodeIf.sv
rtl/instrDecoder.sv
rtl/controlSequencer.sv
rtl/controlEncoder.sv
rtl/controlUnit.sv
sim/controlUnit_sva.sv
sim/controlUnitTb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/controlUnitPkg.sv
      - rtl/decodeIf.sv
      - rtl/instrDecoder.sv
      - rtl/controlSequencer.sv
      - rtl/controlEncoder.sv
      - rtl/controlUnit.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/controlUnit_sva.sv
      - sim/controlUnitTb.sv
